// ==== core_pkg.sv ====
`default_nettype none

package core_pkg;

  localparam int XLEN   = 32;
  localparam int REG_AW = 5;
  localparam int TAG_W  = 16;  // stands in for the pc

  // decoded micro-op operations
  typedef enum logic [4:0] {
    OP_ADDU,
    OP_SUBU,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_NOR,
    OP_SLT,
    OP_SLTU,
    OP_SLL,
    OP_SRL,
    OP_SRA,
    OP_LUI,
    OP_MULT,
    OP_MULTU,
    OP_DIV,
    OP_DIVU,
    OP_MFHI,
    OP_MFLO
  } uop_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_NOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_LUI
  } alu_op_e;

  typedef struct packed {
    uop_e              op;
    logic [REG_AW-1:0] rs;
    logic [REG_AW-1:0] rt;
    logic [REG_AW-1:0] rd;
    logic              use_imm;
    logic [15:0]       imm;    // zero-extended for logic ops, else sign-extended
    logic [4:0]        shamt;
    logic [TAG_W-1:0]  tag;
  } uop_t;

  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic              rf_wen;
    logic [REG_AW-1:0] rf_wnum;
    logic [XLEN-1:0]   rf_wdata;
  } wb_trace_t;

  typedef enum logic [0:0] {
    MDU_IDLE,
    MDU_DIV
  } mdu_state_e;

endpackage

`default_nettype wire

// ==== regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile (
  input  logic                        clk,
  input  logic                        rst_i,
  input  logic [core_pkg::REG_AW-1:0] raddr_a_i,
  input  logic [core_pkg::REG_AW-1:0] raddr_b_i,
  input  logic                        we_i,
  input  logic [core_pkg::REG_AW-1:0] waddr_i,
  input  logic [core_pkg::XLEN-1:0]   wdata_i,
  output logic [core_pkg::XLEN-1:0]   rdata_a_o,
  output logic [core_pkg::XLEN-1:0]   rdata_b_o
);
  import core_pkg::*;

  localparam int NREGS = 2 ** REG_AW;

  logic [XLEN-1:0] regs [0:NREGS-1];

  // r0 is cleared here and never written
  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // async read, bypass lives in exec_pipe
  assign rdata_a_o = regs[raddr_a_i];
  assign rdata_b_o = regs[raddr_b_i];

endmodule

`default_nettype wire

// ==== alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  core_pkg::alu_op_e         op_i,
  input  logic [core_pkg::XLEN-1:0] a_i,
  input  logic [core_pkg::XLEN-1:0] b_i,
  input  logic [4:0]                shamt_i,
  output logic [core_pkg::XLEN-1:0] res_o
);
  import core_pkg::*;

  logic [XLEN-1:0] sum;
  logic [XLEN-1:0] diff;
  logic            lt_s;
  logic            lt_u;

  assign sum  = a_i + b_i;
  assign diff = a_i - b_i;
  assign lt_s = $signed(a_i) < $signed(b_i);
  assign lt_u = a_i < b_i;

  always_comb begin
    case (op_i)
      ALU_ADD:  res_o = sum;
      ALU_SUB:  res_o = diff;
      ALU_AND:  res_o = a_i & b_i;
      ALU_OR:   res_o = a_i | b_i;
      ALU_XOR:  res_o = a_i ^ b_i;
      ALU_NOR:  res_o = ~(a_i | b_i);
      ALU_SLT:  res_o = {{(XLEN-1){1'b0}}, lt_s};
      ALU_SLTU: res_o = {{(XLEN-1){1'b0}}, lt_u};
      // shifts act on b, like rt in the isa
      ALU_SLL:  res_o = b_i << shamt_i;
      ALU_SRL:  res_o = b_i >> shamt_i;
      ALU_SRA:  res_o = $signed(b_i) >>> shamt_i;
      ALU_LUI:  res_o = b_i << 16;
      default:  res_o = sum;
    endcase
  end

endmodule

`default_nettype wire

// ==== mdu.sv ====
`timescale 1ns/1ps
`default_nettype none

module mdu #(
  parameter int DIV_BITS_PER_CYCLE = 1
) (
  input  logic                      clk,
  input  logic                      rst_i,
  input  logic                      start_i,
  input  core_pkg::uop_e            op_i,
  input  logic [core_pkg::XLEN-1:0] opa_i,
  input  logic [core_pkg::XLEN-1:0] opb_i,
  output logic                      busy_o,
  output logic [core_pkg::XLEN-1:0] hi_o,
  output logic [core_pkg::XLEN-1:0] lo_o
);
  import core_pkg::*;

  localparam int STEPS = XLEN / DIV_BITS_PER_CYCLE;
  localparam int CNT_W = $clog2(STEPS + 1);

  mdu_state_e        state;
  logic [CNT_W-1:0]  cnt;
  logic              last;
  logic              is_div;
  logic              is_signed;
  logic [2*XLEN-1:0] ext_a;
  logic [2*XLEN-1:0] ext_b;
  logic [2*XLEN-1:0] prod;
  logic [XLEN-1:0]   mag_a;
  logic [XLEN-1:0]   mag_b;
  logic [XLEN-1:0]   quo;
  logic [XLEN-1:0]   rem;
  logic [XLEN-1:0]   dvs;
  logic [XLEN-1:0]   quo_nx;
  logic [XLEN-1:0]   rem_nx;
  logic [XLEN:0]     shifted;
  logic [XLEN+1:0]   trial;
  logic              neg_q;
  logic              neg_r;

  assign is_div    = op_i inside {OP_DIV, OP_DIVU};
  assign is_signed = op_i inside {OP_MULT, OP_DIV};
  assign last      = cnt == CNT_W'(STEPS);  // sign fix cycle

  assign ext_a = is_signed ? {{XLEN{opa_i[XLEN-1]}}, opa_i} : {{XLEN{1'b0}}, opa_i};
  assign ext_b = is_signed ? {{XLEN{opb_i[XLEN-1]}}, opb_i} : {{XLEN{1'b0}}, opb_i};
  assign prod  = ext_a * ext_b;  // low 2*XLEN bits are right for both signs
  assign mag_a = (is_signed && opa_i[XLEN-1]) ? -opa_i : opa_i;
  assign mag_b = (is_signed && opb_i[XLEN-1]) ? -opb_i : opb_i;

  // restoring steps, DIV_BITS_PER_CYCLE per clock
  always_comb begin
    rem_nx  = rem;
    quo_nx  = quo;
    shifted = '0;
    trial   = '0;
    for (int i = 0; i < DIV_BITS_PER_CYCLE; i++) begin
      shifted = {rem_nx, quo_nx[XLEN-1]};
      trial   = {1'b0, shifted} - {2'b00, dvs};
      if (trial[XLEN+1]) begin
        rem_nx = shifted[XLEN-1:0];
        quo_nx = {quo_nx[XLEN-2:0], 1'b0};
      end else begin
        rem_nx = trial[XLEN-1:0];
        quo_nx = {quo_nx[XLEN-2:0], 1'b1};
      end
    end
  end

  // low in the fix cycle so the div can leave EX as HI/LO land
  assign busy_o = (state == MDU_IDLE) ? (start_i && is_div) : !last;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state <= MDU_IDLE;
      cnt   <= '0;
      hi_o  <= '0;
      lo_o  <= '0;
    end else begin
      case (state)
        MDU_IDLE: begin
          if (start_i && is_div) begin
            state <= MDU_DIV;
            cnt   <= '0;
          end else if (start_i) begin
            hi_o <= prod[2*XLEN-1:XLEN];
            lo_o <= prod[XLEN-1:0];
          end
        end
        MDU_DIV: begin
          if (last) begin
            state <= MDU_IDLE;
            hi_o  <= neg_r ? -rem : rem;  // remainder follows the dividend
            lo_o  <= neg_q ? -quo : quo;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == MDU_IDLE && start_i) begin
      quo   <= mag_a;
      rem   <= '0;
      dvs   <= mag_b;
      neg_q <= is_signed && (opa_i[XLEN-1] ^ opb_i[XLEN-1]);
      neg_r <= is_signed && opa_i[XLEN-1];
    end else if (state == MDU_DIV && !last) begin
      quo <= quo_nx;
      rem <= rem_nx;
    end
  end

endmodule

`default_nettype wire

// ==== exec_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_pipe #(
  parameter int DIV_BITS_PER_CYCLE = 1
) (
  input  logic                        clk,
  input  logic                        rst_i,
  input  logic                        issue_valid_i,
  input  core_pkg::uop_t              issue_uop_i,
  input  logic [core_pkg::XLEN-1:0]   rf_rdata_a_i,
  input  logic [core_pkg::XLEN-1:0]   rf_rdata_b_i,
  output logic                        issue_stall_o,
  output logic [core_pkg::REG_AW-1:0] rf_raddr_a_o,
  output logic [core_pkg::REG_AW-1:0] rf_raddr_b_o,
  output logic                        rf_we_o,
  output logic [core_pkg::REG_AW-1:0] rf_waddr_o,
  output logic [core_pkg::XLEN-1:0]   rf_wdata_o,
  output logic                        trace_valid_o,
  output core_pkg::wb_trace_t         trace_o
);
  import core_pkg::*;

  logic            ex_valid;
  uop_t            ex_uop;
  logic [XLEN-1:0] ex_a;
  logic [XLEN-1:0] ex_b;
  logic            ex_wen;
  logic [XLEN-1:0] ex_res;
  logic [XLEN-1:0] alu_res;
  alu_op_e         alu_op;
  logic [XLEN-1:0] imm_ext;
  logic [XLEN-1:0] src_a;
  logic [XLEN-1:0] src_b;
  logic            mdu_busy;
  logic [XLEN-1:0] hi;
  logic [XLEN-1:0] lo;
  logic            wb_valid;
  wb_trace_t       wb_q;

  function automatic logic is_mdu(uop_e op);
    return op inside {OP_MULT, OP_MULTU, OP_DIV, OP_DIVU};
  endfunction

  function automatic logic is_alu(uop_e op);
    return !(is_mdu(op) || op inside {OP_MFHI, OP_MFLO});
  endfunction

  // EX result first, then WB, then the regfile
  function automatic logic [XLEN-1:0] bypass(logic [REG_AW-1:0] addr, logic [XLEN-1:0] rf_val);
    if (ex_wen && ex_uop.rd == addr) begin
      return ex_res;
    end else if (wb_valid && wb_q.rf_wen && wb_q.rf_wnum == addr) begin
      return wb_q.rf_wdata;
    end
    return rf_val;
  endfunction

  assign rf_raddr_a_o = issue_uop_i.rs;
  assign rf_raddr_b_o = issue_uop_i.rt;

  always_comb begin
    if (issue_uop_i.op inside {OP_AND, OP_OR, OP_XOR, OP_NOR}) begin
      imm_ext = {{(XLEN-16){1'b0}}, issue_uop_i.imm};
    end else begin
      imm_ext = {{(XLEN-16){issue_uop_i.imm[15]}}, issue_uop_i.imm};
    end
  end

  always_comb begin
    src_a = bypass(issue_uop_i.rs, rf_rdata_a_i);
    src_b = bypass(issue_uop_i.rt, rf_rdata_b_i);
    if (issue_uop_i.use_imm && is_alu(issue_uop_i.op)) begin
      src_b = imm_ext;
    end
  end

  assign issue_stall_o = mdu_busy;  // only the divider holds issue

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ex_valid <= 1'b0;
    end else if (!mdu_busy) begin
      ex_valid <= issue_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!mdu_busy) begin
      ex_uop <= issue_uop_i;
      ex_a   <= src_a;
      ex_b   <= src_b;
    end
  end

  always_comb begin
    case (ex_uop.op)
      OP_SUBU: alu_op = ALU_SUB;
      OP_AND:  alu_op = ALU_AND;
      OP_OR:   alu_op = ALU_OR;
      OP_XOR:  alu_op = ALU_XOR;
      OP_NOR:  alu_op = ALU_NOR;
      OP_SLT:  alu_op = ALU_SLT;
      OP_SLTU: alu_op = ALU_SLTU;
      OP_SLL:  alu_op = ALU_SLL;
      OP_SRL:  alu_op = ALU_SRL;
      OP_SRA:  alu_op = ALU_SRA;
      OP_LUI:  alu_op = ALU_LUI;
      default: alu_op = ALU_ADD;
    endcase
  end

  alu i_alu (
    .op_i    (alu_op),
    .a_i     (ex_a),
    .b_i     (ex_b),
    .shamt_i (ex_uop.shamt),
    .res_o   (alu_res)
  );

  mdu #(
    .DIV_BITS_PER_CYCLE (DIV_BITS_PER_CYCLE)
  ) i_mdu (
    .clk     (clk),
    .rst_i   (rst_i),
    .start_i (ex_valid && is_mdu(ex_uop.op)),
    .op_i    (ex_uop.op),
    .opa_i   (ex_a),
    .opb_i   (ex_b),
    .busy_o  (mdu_busy),
    .hi_o    (hi),
    .lo_o    (lo)
  );

  always_comb begin
    case (ex_uop.op)
      OP_MFHI:                              ex_res = hi;
      OP_MFLO:                              ex_res = lo;
      OP_MULT, OP_MULTU, OP_DIV, OP_DIVU:  ex_res = '0;  // no gpr result
      default:                              ex_res = alu_res;
    endcase
  end

  assign ex_wen = ex_valid && !is_mdu(ex_uop.op) && ex_uop.rd != '0;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= ex_valid && !mdu_busy;  // bubble while a div sits in EX
    end
  end

  always_ff @(posedge clk) begin
    wb_q.tag      <= ex_uop.tag;
    wb_q.rf_wen   <= ex_wen;
    wb_q.rf_wnum  <= ex_uop.rd;
    wb_q.rf_wdata <= ex_res;
  end

  assign rf_we_o       = wb_valid && wb_q.rf_wen;
  assign rf_waddr_o    = wb_q.rf_wnum;
  assign rf_wdata_o    = wb_q.rf_wdata;
  assign trace_valid_o = wb_valid;
  assign trace_o       = wb_q;

endmodule

`default_nettype wire

// ==== core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_top #(
  parameter int DIV_BITS_PER_CYCLE = 1  // 1, 2 or 4
) (
  input  logic                clk,
  input  logic                rst_i,
  input  logic                issue_valid_i,
  input  core_pkg::uop_t      issue_uop_i,
  output logic                issue_stall_o,
  output logic                trace_valid_o,
  output core_pkg::wb_trace_t trace_o
);
  import core_pkg::*;

  logic [REG_AW-1:0] rf_raddr_a;
  logic [REG_AW-1:0] rf_raddr_b;
  logic [XLEN-1:0]   rf_rdata_a;
  logic [XLEN-1:0]   rf_rdata_b;
  logic              rf_we;
  logic [REG_AW-1:0] rf_waddr;
  logic [XLEN-1:0]   rf_wdata;

  regfile i_regfile (
    .clk       (clk),
    .rst_i     (rst_i),
    .raddr_a_i (rf_raddr_a),
    .raddr_b_i (rf_raddr_b),
    .we_i      (rf_we),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b)
  );

  exec_pipe #(
    .DIV_BITS_PER_CYCLE (DIV_BITS_PER_CYCLE)
  ) i_exec_pipe (
    .clk           (clk),
    .rst_i         (rst_i),
    .issue_valid_i (issue_valid_i),
    .issue_uop_i   (issue_uop_i),
    .rf_rdata_a_i  (rf_rdata_a),
    .rf_rdata_b_i  (rf_rdata_b),
    .issue_stall_o (issue_stall_o),
    .rf_raddr_a_o  (rf_raddr_a),
    .rf_raddr_b_o  (rf_raddr_b),
    .rf_we_o       (rf_we),
    .rf_waddr_o    (rf_waddr),
    .rf_wdata_o    (rf_wdata),
    .trace_valid_o (trace_valid_o),
    .trace_o       (trace_o)
  );

endmodule

`default_nettype wire

// ==== tb_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
  input  logic                clk,
  input  logic                rst_i,
  input  logic                issue_valid_i,
  input  logic                issue_stall_i,
  input  core_pkg::uop_t      issue_uop_i,
  input  logic                trace_valid_i,
  input  core_pkg::wb_trace_t trace_i,
  input  logic                test_end_i,
  input  logic [2:0]          test_id_i,
  output logic                idle_o,
  output int                  err_cnt_o,
  output int                  chk_cnt_o
);
  import core_pkg::*;

  logic [XLEN-1:0] regs [0:31];
  logic [XLEN-1:0] hi;
  logic [XLEN-1:0] lo;
  wb_trace_t       exp_q [$];
  int              test_err = 0;
  int              test_chk = 0;
  int              stall_cyc = 0;
  int              err_total = 0;
  int              chk_total = 0;

  assign err_cnt_o = err_total;
  assign chk_cnt_o = chk_total;

  function automatic string test_name(logic [2:0] id);
    case (id)
      3'd1:    return "alu_random";
      3'd2:    return "bypass";
      3'd3:    return "multiply";
      3'd4:    return "divide";
      default: return "r0_reset";
    endcase
  endfunction

  task automatic compare(string name, logic [31:0] got, logic [31:0] exp, logic [15:0] tag);
    if (got !== exp) begin
      $display("FAIL %s tag %h: got %h, expected %h", name, tag, got, exp);
      test_err++;
    end
  endtask

  // reference model in program order
  function automatic wb_trace_t model_step(uop_t u);
    wb_trace_t         t;
    logic [XLEN-1:0]   a;
    logic [XLEN-1:0]   b;
    logic [XLEN-1:0]   res;
    logic [XLEN-1:0]   ma;
    logic [XLEN-1:0]   mb;
    logic [XLEN-1:0]   q;
    logic [XLEN-1:0]   rm;
    logic [2*XLEN-1:0] p;
    logic              sgn;
    a = regs[u.rs];
    b = regs[u.rt];
    if (u.use_imm && !(u.op inside {OP_MULT, OP_MULTU, OP_DIV, OP_DIVU, OP_MFHI, OP_MFLO})) begin
      if (u.op inside {OP_AND, OP_OR, OP_XOR, OP_NOR}) begin
        b = {16'h0, u.imm};
      end else begin
        b = {{16{u.imm[15]}}, u.imm};
      end
    end
    sgn = u.op inside {OP_MULT, OP_DIV};
    ma  = (sgn && a[31]) ? -a : a;
    mb  = (sgn && b[31]) ? -b : b;
    res = '0;
    t.tag     = u.tag;
    t.rf_wnum = u.rd;
    t.rf_wen  = u.rd != '0;
    case (u.op)
      OP_ADDU: res = a + b;
      OP_SUBU: res = a - b;
      OP_AND:  res = a & b;
      OP_OR:   res = a | b;
      OP_XOR:  res = a ^ b;
      OP_NOR:  res = ~(a | b);
      OP_SLT:  res = {31'b0, $signed(a) < $signed(b)};
      OP_SLTU: res = {31'b0, a < b};
      OP_SLL:  res = b << u.shamt;
      OP_SRL:  res = b >> u.shamt;
      OP_SRA:  res = $signed(b) >>> u.shamt;
      OP_LUI:  res = {b[15:0], 16'h0};
      OP_MFHI: res = hi;
      OP_MFLO: res = lo;
      OP_MULT, OP_MULTU: begin
        p = {32'b0, ma} * {32'b0, mb};  // product of magnitudes
        if (sgn && (a[31] ^ b[31])) begin
          p = -p;
        end
        hi = p[63:32];
        lo = p[31:0];
        t.rf_wen = 1'b0;
      end
      default: begin
        q  = (mb == '0) ? '1 : ma / mb;  // divide by zero gives all ones
        rm = (mb == '0) ? ma : ma % mb;
        lo = (sgn && (a[31] ^ b[31])) ? -q : q;
        hi = (sgn && a[31]) ? -rm : rm;
        t.rf_wen = 1'b0;
      end
    endcase
    t.rf_wdata = res;
    if (t.rf_wen) begin
      regs[u.rd] = res;
    end
    return t;
  endfunction

  always @(posedge clk) begin
    wb_trace_t exp_t;
    if (rst_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] = '0;
      end
      hi = '0;
      lo = '0;
      exp_q.delete();
    end else begin
      if (trace_valid_i) begin
        if (exp_q.size() == 0) begin
          $display("trace with tag %h arrived with no micro-op pending", trace_i.tag);
          test_err++;
        end else begin
          exp_t = exp_q.pop_front();
          test_chk++;
          compare("trace_o.tag", 32'(trace_i.tag), 32'(exp_t.tag), exp_t.tag);
          compare("trace_o.rf_wen", 32'(trace_i.rf_wen), 32'(exp_t.rf_wen), exp_t.tag);
          compare("trace_o.rf_wnum", 32'(trace_i.rf_wnum), 32'(exp_t.rf_wnum), exp_t.tag);
          if (exp_t.rf_wen) begin  // data only matters when written
            compare("trace_o.rf_wdata", trace_i.rf_wdata, exp_t.rf_wdata, exp_t.tag);
          end
        end
      end
      if (issue_valid_i && !issue_stall_i) begin
        exp_q.push_back(model_step(issue_uop_i));
      end
      if (issue_stall_i) begin
        stall_cyc++;
      end
      if (test_end_i) begin
        if (test_id_i == 3'd4 && stall_cyc == 0) begin
          $display("test 4 divide: issue_stall_o never went high");
          test_err++;
        end
        $display("test %0d %s: %s, %0d traces checked, %0d errors", test_id_i,
                 test_name(test_id_i), (test_err == 0) ? "PASS" : "FAIL", test_chk, test_err);
        err_total += test_err;
        chk_total += test_chk;
        test_err  = 0;
        test_chk  = 0;
        stall_cyc = 0;
      end
    end
    idle_o <= exp_q.size() == 0;
  end

endmodule

`default_nettype wire

// ==== tb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_top;
  import core_pkg::*;

  localparam int DIV_BPC  = 2;
  localparam int N_OPS    = 484;  // 200 + 100 + 84 + 84 + 16
  localparam int WD_LIMIT = N_OPS * 40 + 200;

  logic              clk;
  logic              rst_i;
  logic              issue_valid_i;
  uop_t              issue_uop_i;
  logic              issue_stall_o;
  logic              trace_valid_o;
  wb_trace_t         trace_o;
  logic              test_end;
  logic [2:0]        test_id;
  logic              idle;
  int                err_cnt;
  int                chk_cnt;
  integer            seed = 32'h36a5;
  logic [TAG_W-1:0]  tag = '0;
  logic [REG_AW-1:0] rd_prev [0:1];

  core_top #(
    .DIV_BITS_PER_CYCLE (DIV_BPC)
  ) i_dut (
    .clk           (clk),
    .rst_i         (rst_i),
    .issue_valid_i (issue_valid_i),
    .issue_uop_i   (issue_uop_i),
    .issue_stall_o (issue_stall_o),
    .trace_valid_o (trace_valid_o),
    .trace_o       (trace_o)
  );

  tb_checker i_checker (
    .clk           (clk),
    .rst_i         (rst_i),
    .issue_valid_i (issue_valid_i),
    .issue_stall_i (issue_stall_o),
    .issue_uop_i   (issue_uop_i),
    .trace_valid_i (trace_valid_o),
    .trace_i       (trace_o),
    .test_end_i    (test_end),
    .test_id_i     (test_id),
    .idle_o        (idle),
    .err_cnt_o     (err_cnt),
    .chk_cnt_o     (chk_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic uop_t random_alu();
    uop_t u;
    u.op      = uop_e'(5'($unsigned($random(seed)) % 12));  // ADDU .. LUI
    u.rs      = REG_AW'($random(seed));
    u.rt      = REG_AW'($random(seed));
    u.rd      = REG_AW'($random(seed));
    u.use_imm = 1'($random(seed));
    u.imm     = 16'($random(seed));
    u.shamt   = 5'($random(seed));
    u.tag     = '0;
    return u;
  endfunction

  // present one micro-op and hold it until accepted
  task automatic send(uop_t u);
    u.tag = tag;
    tag   = tag + 1'b1;
    issue_valid_i <= 1'b1;
    issue_uop_i   <= u;
    @(posedge clk);
    while (issue_stall_o) begin
      @(posedge clk);
    end
    rd_prev[1] = rd_prev[0];
    rd_prev[0] = u.rd;
  endtask

  task automatic load_reg(logic [REG_AW-1:0] r, logic [XLEN-1:0] val);
    uop_t u;
    u         = '0;
    u.op      = OP_LUI;
    u.rd      = r;
    u.use_imm = 1'b1;
    u.imm     = val[31:16];
    send(u);
    u.op  = OP_OR;
    u.rs  = r;
    u.imm = val[15:0];
    send(u);
  endtask

  task automatic mdu_seq(uop_e op, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
    uop_t u;
    load_reg(5'd4, a);
    load_reg(5'd5, b);
    u    = '0;
    u.op = op;
    u.rs = 5'd4;
    u.rt = 5'd5;
    u.rd = REG_AW'($random(seed));  // no gpr write expected
    send(u);
    u.op = OP_MFHI;
    u.rd = 5'd6;
    send(u);
    u.op = OP_MFLO;
    u.rd = 5'd7;
    send(u);
  endtask

  task automatic apply_reset();
    rst_i         <= 1'b1;
    issue_valid_i <= 1'b0;
    repeat (4) @(posedge clk);
    rst_i <= 1'b0;
  endtask

  // drain the pipe, then let the checker report
  task automatic finish_test(logic [2:0] id);
    issue_valid_i <= 1'b0;
    @(posedge clk);
    while (!idle) begin
      @(posedge clk);
    end
    test_end <= 1'b1;
    test_id  <= id;
    @(posedge clk);
    test_end <= 1'b0;
    @(posedge clk);
  endtask

  initial begin
    uop_t            u;
    logic [XLEN-1:0] b;
    rst_i         = 1'b1;
    issue_valid_i = 1'b0;
    issue_uop_i   = '0;
    test_end      = 1'b0;
    test_id       = '0;
    rd_prev[0]    = '0;
    rd_prev[1]    = '0;
    repeat (4) @(posedge clk);
    rst_i <= 1'b0;
    repeat (200) send(random_alu());
    finish_test(3'd1);
    for (int i = 0; i < 100; i++) begin
      u         = random_alu();
      u.use_imm = 1'b0;
      u.rs      = rd_prev[1'($random(seed))];  // one or two ops back
      u.rt      = rd_prev[1'($random(seed))];
      send(u);
    end
    finish_test(3'd2);
    for (int i = 0; i < 12; i++) begin
      mdu_seq((i % 2 == 0) ? OP_MULT : OP_MULTU, $random(seed), $random(seed));
    end
    finish_test(3'd3);
    for (int i = 0; i < 12; i++) begin
      case (i % 4)
        0:       b = '0;
        1:       b = 32'hffff_ff00 | 32'($random(seed));  // small negative
        2:       b = $random(seed);
        default: b = {24'h0, 8'($random(seed))} | 32'h1;
      endcase
      mdu_seq((i % 3 == 0) ? OP_DIVU : OP_DIV, $random(seed), b);
    end
    finish_test(3'd4);
    apply_reset();
    for (int i = 0; i < 8; i++) begin
      u    = random_alu();
      u.rd = '0;
      send(u);
    end
    // r20..r27 untouched since reset
    for (int i = 0; i < 8; i++) begin
      u    = '0;
      u.op = (i % 2 == 0) ? OP_OR : OP_ADDU;
      u.rd = REG_AW'(i + 1);
      u.rt = REG_AW'(i + 20);
      send(u);
    end
    finish_test(3'd5);
    $display("total: %0d traces checked, %0d errors", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin
    repeat (WD_LIMIT) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles", WD_LIMIT);
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
core_pkg.sv
regfile.sv
alu.sv
mdu.sv
exec_pipe.sv
core_top.sv
tb_checker.sv
tb_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --top-module tb_top -f flist.f -o sim_tb 2>&1 | tee build.log
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb 2>&1 | tee "$LOG"
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
  echo "simulation exited with an error"
  exit 1
fi

if grep -q "Regression failed" "$LOG"; then
  exit 1
fi
if ! grep -q "Regression passed" "$LOG"; then
  echo "no result line in $LOG"
  exit 1
fi
exit 0
